// ==== rvx_params.svh ====
`ifndef RVX_PARAMS_SVH
`define RVX_PARAMS_SVH

`define RVX_XLEN   64 // data path and AXI data width
`define RVX_ILEN   32
`define RVX_REG_AW 5
`define RVX_AXI_AW 32

`endif

// ==== rvx_pkg.sv ====
`default_nettype none
`include "rvx_params.svh"

package rvx_pkg;

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_ADDW,
        ALU_SUBW,
        ALU_SLLW,
        ALU_MUL,
        ALU_DIVU,
        ALU_REMU
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } br_cond_e;

    typedef enum logic [2:0] {
        LD_NONE,
        LD_LB,
        LD_LBU,
        LD_LW,
        LD_LWU,
        LD_LD
    } load_kind_e;

    typedef struct packed {
        alu_op_e                alu_op;
        br_cond_e               br_cond;
        load_kind_e             load_kind;
        logic [`RVX_XLEN-1:0]   a;
        logic [`RVX_XLEN-1:0]   b;
        logic [`RVX_XLEN-1:0]   offset;    // branch offset
        logic [`RVX_XLEN-1:0]   pc;
        logic [`RVX_REG_AW-1:0] rd;
        logic                   wen;
        logic                   illegal;
    } dec_op_t;

    typedef struct packed {
        logic [`RVX_XLEN-1:0]   value;
        logic [`RVX_REG_AW-1:0] rd;
        logic                   wen;
        load_kind_e             load_kind;
        logic [`RVX_XLEN-1:0]   addr;      // load address
        logic                   taken;
        logic [`RVX_XLEN-1:0]   target;
        logic                   err;
    } exe_res_t;

endpackage

`default_nettype wire

// ==== rvx_stage_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface rvx_stage_if #(
    parameter type payload_t = logic
);

    logic     valid;
    logic     ready;
    payload_t payload;

    modport source (
        output valid,
        output payload,
        input  ready
    );

    modport sink (
        input  valid,
        input  payload,
        output ready
    );

endinterface

`default_nettype wire

// ==== rvx_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rvx_params.svh"

module rvx_decode (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  logic [`RVX_ILEN-1:0] in_instr,
    input  logic [`RVX_XLEN-1:0] in_rs1,
    input  logic [`RVX_XLEN-1:0] in_rs2,
    input  logic [`RVX_XLEN-1:0] in_pc,
    rvx_stage_if.source          dec
);

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic [`RVX_XLEN-1:0] imm_i;
    logic [`RVX_XLEN-1:0] imm_u;
    logic [`RVX_XLEN-1:0] imm_b;
    logic                 illegal;
    rvx_pkg::dec_op_t     op;

    assign opcode = in_instr[6:0];
    assign funct3 = in_instr[14:12];
    assign funct7 = in_instr[31:25];
    assign imm_i  = {{(`RVX_XLEN-12){in_instr[31]}}, in_instr[31:20]};
    assign imm_u  = {{(`RVX_XLEN-32){in_instr[31]}}, in_instr[31:12], 12'b0};
    assign imm_b  = {{(`RVX_XLEN-13){in_instr[31]}}, in_instr[31], in_instr[7],
                     in_instr[30:25], in_instr[11:8], 1'b0};

    always_comb begin
        illegal      = 1'b0;
        op.alu_op    = rvx_pkg::ALU_ADD;
        op.br_cond   = rvx_pkg::BR_NONE;
        op.load_kind = rvx_pkg::LD_NONE;
        op.a         = in_rs1;
        op.b         = in_rs2;
        op.offset    = imm_b;
        op.pc        = in_pc;
        op.rd        = in_instr[11:7];
        op.wen       = 1'b1;
        case (opcode)
            7'b0110111: begin // lui
                op.a = '0;
                op.b = imm_u;
            end
            7'b0010111: begin // auipc
                op.a = in_pc;
                op.b = imm_u;
            end
            7'b0010011: begin
                op.b = imm_i;
                case (funct3)
                    3'b000: op.alu_op = rvx_pkg::ALU_ADD;
                    3'b010: op.alu_op = rvx_pkg::ALU_SLT;
                    3'b011: op.alu_op = rvx_pkg::ALU_SLTU;
                    3'b100: op.alu_op = rvx_pkg::ALU_XOR;
                    3'b110: op.alu_op = rvx_pkg::ALU_OR;
                    3'b111: op.alu_op = rvx_pkg::ALU_AND;
                    3'b001: begin
                        op.alu_op = rvx_pkg::ALU_SLL;
                        illegal   = (in_instr[31:26] != 6'b000000);
                    end
                    default: begin // srli / srai share funct3
                        op.alu_op = in_instr[30] ? rvx_pkg::ALU_SRA : rvx_pkg::ALU_SRL;
                        illegal   = ({in_instr[31], in_instr[29:26]} != 5'b00000);
                    end
                endcase
            end
            7'b0110011: begin
                case ({funct7, funct3})
                    {7'h00, 3'b000}: op.alu_op = rvx_pkg::ALU_ADD;
                    {7'h20, 3'b000}: op.alu_op = rvx_pkg::ALU_SUB;
                    {7'h00, 3'b001}: op.alu_op = rvx_pkg::ALU_SLL;
                    {7'h00, 3'b010}: op.alu_op = rvx_pkg::ALU_SLT;
                    {7'h00, 3'b011}: op.alu_op = rvx_pkg::ALU_SLTU;
                    {7'h00, 3'b100}: op.alu_op = rvx_pkg::ALU_XOR;
                    {7'h00, 3'b101}: op.alu_op = rvx_pkg::ALU_SRL;
                    {7'h20, 3'b101}: op.alu_op = rvx_pkg::ALU_SRA;
                    {7'h00, 3'b110}: op.alu_op = rvx_pkg::ALU_OR;
                    {7'h00, 3'b111}: op.alu_op = rvx_pkg::ALU_AND;
                    {7'h01, 3'b000}: op.alu_op = rvx_pkg::ALU_MUL;
                    {7'h01, 3'b101}: op.alu_op = rvx_pkg::ALU_DIVU;
                    {7'h01, 3'b111}: op.alu_op = rvx_pkg::ALU_REMU;
                    default:         illegal   = 1'b1;
                endcase
            end
            7'b0111011: begin // word forms
                case ({funct7, funct3})
                    {7'h00, 3'b000}: op.alu_op = rvx_pkg::ALU_ADDW;
                    {7'h20, 3'b000}: op.alu_op = rvx_pkg::ALU_SUBW;
                    {7'h00, 3'b001}: op.alu_op = rvx_pkg::ALU_SLLW;
                    default:         illegal   = 1'b1;
                endcase
            end
            7'b0000011: begin
                op.b = imm_i; // address is rs1 + imm
                case (funct3)
                    3'b000:  op.load_kind = rvx_pkg::LD_LB;
                    3'b100:  op.load_kind = rvx_pkg::LD_LBU;
                    3'b010:  op.load_kind = rvx_pkg::LD_LW;
                    3'b110:  op.load_kind = rvx_pkg::LD_LWU;
                    3'b011:  op.load_kind = rvx_pkg::LD_LD;
                    default: illegal      = 1'b1;
                endcase
            end
            7'b1100011: begin
                op.wen = 1'b0;
                case (funct3)
                    3'b000:  op.br_cond = rvx_pkg::BR_EQ;
                    3'b001:  op.br_cond = rvx_pkg::BR_NE;
                    3'b100:  op.br_cond = rvx_pkg::BR_LT;
                    3'b101:  op.br_cond = rvx_pkg::BR_GE;
                    3'b110:  op.br_cond = rvx_pkg::BR_LTU;
                    3'b111:  op.br_cond = rvx_pkg::BR_GEU;
                    default: illegal    = 1'b1;
                endcase
            end
            default: illegal = 1'b1;
        endcase
        op.illegal = illegal;
        if (illegal) begin
            op.br_cond   = rvx_pkg::BR_NONE;
            op.load_kind = rvx_pkg::LD_NONE;
        end
        if (illegal || op.rd == '0) begin
            op.wen = 1'b0; // x0 is never written
        end
    end

    assign in_ready = !dec.valid || dec.ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec.valid <= 1'b0;
        end else if (in_ready) begin
            dec.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            dec.payload <= op;
        end
    end

    a_dec_stable: assert property (@(posedge clk) disable iff (!arst_n)
        dec.valid && !dec.ready |=> dec.valid && $stable(dec.payload));

endmodule

`default_nettype wire

// ==== rvx_alu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rvx_params.svh"

module rvx_alu (
    input logic         clk,
    input logic         arst_n,
    rvx_stage_if.sink   dec,
    rvx_stage_if.source exe
);

    rvx_pkg::dec_op_t     op;
    rvx_pkg::exe_res_t    res;
    logic [`RVX_XLEN-1:0] a;
    logic [`RVX_XLEN-1:0] b;
    logic [`RVX_XLEN-1:0] value;
    logic [`RVX_XLEN-1:0] addr;
    logic                 taken;
    logic                 misaligned;

    function automatic logic [`RVX_XLEN-1:0] sext_w(input logic [31:0] w);
        return {{(`RVX_XLEN-32){w[31]}}, w};
    endfunction

    assign op = dec.payload;
    assign a  = op.a;
    assign b  = op.b;

    always_comb begin
        case (op.alu_op)
            rvx_pkg::ALU_SUB:  value = a - b;
            rvx_pkg::ALU_AND:  value = a & b;
            rvx_pkg::ALU_OR:   value = a | b;
            rvx_pkg::ALU_XOR:  value = a ^ b;
            rvx_pkg::ALU_SLL:  value = a << b[5:0];
            rvx_pkg::ALU_SRL:  value = a >> b[5:0];
            rvx_pkg::ALU_SRA:  value = $unsigned($signed(a) >>> b[5:0]);
            rvx_pkg::ALU_SLT:  value = {{(`RVX_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            rvx_pkg::ALU_SLTU: value = {{(`RVX_XLEN-1){1'b0}}, a < b};
            rvx_pkg::ALU_ADDW: value = sext_w(a[31:0] + b[31:0]);
            rvx_pkg::ALU_SUBW: value = sext_w(a[31:0] - b[31:0]);
            rvx_pkg::ALU_SLLW: value = sext_w(a[31:0] << b[4:0]);
            rvx_pkg::ALU_MUL:  value = a * b; // low half only
            rvx_pkg::ALU_DIVU: value = (b == '0) ? '1 : a / b;
            rvx_pkg::ALU_REMU: value = (b == '0) ? a : a % b;
            default:           value = a + b;
        endcase
    end

    always_comb begin
        case (op.br_cond)
            rvx_pkg::BR_EQ:  taken = (a == b);
            rvx_pkg::BR_NE:  taken = (a != b);
            rvx_pkg::BR_LT:  taken = ($signed(a) < $signed(b));
            rvx_pkg::BR_GE:  taken = ($signed(a) >= $signed(b));
            rvx_pkg::BR_LTU: taken = (a < b);
            rvx_pkg::BR_GEU: taken = (a >= b);
            default:         taken = 1'b0;
        endcase
    end

    assign addr = a + b;

    always_comb begin
        case (op.load_kind)
            rvx_pkg::LD_LW,
            rvx_pkg::LD_LWU: misaligned = (addr[1:0] != 2'b00);
            rvx_pkg::LD_LD:  misaligned = (addr[2:0] != 3'b000);
            default:         misaligned = 1'b0; // bytes never misaligned
        endcase
    end

    always_comb begin
        res.value     = value;
        res.rd        = op.rd;
        res.wen       = op.wen && !misaligned;
        res.load_kind = op.load_kind;
        res.addr      = addr;
        res.taken     = taken;
        res.target    = op.pc + op.offset;
        res.err       = op.illegal || misaligned;
    end

    assign dec.ready = !exe.valid || exe.ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exe.valid <= 1'b0;
        end else if (dec.ready) begin
            exe.valid <= dec.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec.valid && dec.ready) begin
            exe.payload <= res;
        end
    end

    a_no_taken_load: assert property (@(posedge clk) disable iff (!arst_n)
        exe.valid |-> !(exe.payload.taken && exe.payload.load_kind != rvx_pkg::LD_NONE));

endmodule

`default_nettype wire

// ==== rvx_result.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rvx_params.svh"

module rvx_result (
    input  logic                   clk,
    input  logic                   arst_n,
    rvx_stage_if.sink              exe,
    output logic [`RVX_AXI_AW-1:0] araddr,
    output logic [2:0]             arprot,
    output logic                   arvalid,
    input  logic                   arready,
    input  logic [`RVX_XLEN-1:0]   rdata,
    input  logic [1:0]             rresp,
    input  logic                   rvalid,
    output logic                   rready,
    output logic                   res_valid,
    input  logic                   res_ready,
    output logic [`RVX_XLEN-1:0]   res_value,
    output logic [`RVX_REG_AW-1:0] res_rd,
    output logic                   res_wen,
    output logic                   res_taken,
    output logic [`RVX_XLEN-1:0]   res_target,
    output logic                   res_err
);

    rvx_pkg::exe_res_t    cur; // load waiting on AXI
    logic                 take;
    logic                 is_load;
    logic                 ar_done;
    logic                 r_done;
    logic                 bus_err;
    logic [`RVX_XLEN-1:0] shifted;
    logic [`RVX_XLEN-1:0] load_val;

    assign exe.ready = !(arvalid || rready) && (!res_valid || res_ready);
    assign take      = exe.valid && exe.ready;
    assign is_load   = (exe.payload.load_kind != rvx_pkg::LD_NONE) && !exe.payload.err;
    assign ar_done   = arvalid && arready;
    assign r_done    = rvalid && rready;
    assign bus_err   = (rresp != 2'b00);

    assign araddr = {cur.addr[`RVX_AXI_AW-1:3], 3'b000};
    assign arprot = 3'b000;

    assign shifted = rdata >> {cur.addr[2:0], 3'b000};

    always_comb begin
        case (cur.load_kind)
            rvx_pkg::LD_LB:  load_val = {{(`RVX_XLEN-8){shifted[7]}}, shifted[7:0]};
            rvx_pkg::LD_LBU: load_val = {{(`RVX_XLEN-8){1'b0}}, shifted[7:0]};
            rvx_pkg::LD_LW:  load_val = {{(`RVX_XLEN-32){shifted[31]}}, shifted[31:0]};
            rvx_pkg::LD_LWU: load_val = {{(`RVX_XLEN-32){1'b0}}, shifted[31:0]};
            default:         load_val = shifted; // ld is always aligned here
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            arvalid   <= 1'b0;
            rready    <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            if (take && is_load) begin
                arvalid <= 1'b1;
            end else if (ar_done) begin
                arvalid <= 1'b0;
            end
            if (ar_done) begin
                rready <= 1'b1;
            end else if (r_done) begin
                rready <= 1'b0;
            end
            if ((take && !is_load) || r_done) begin
                res_valid <= 1'b1;
            end else if (res_ready) begin
                res_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && is_load) begin
            cur <= exe.payload;
        end
        if (take && !is_load) begin
            res_value  <= exe.payload.value;
            res_rd     <= exe.payload.rd;
            res_wen    <= exe.payload.wen;
            res_taken  <= exe.payload.taken;
            res_target <= exe.payload.target;
            res_err    <= exe.payload.err;
        end else if (r_done) begin
            res_value  <= bus_err ? '0 : load_val;
            res_rd     <= cur.rd;
            res_wen    <= cur.wen && !bus_err;
            res_taken  <= 1'b0;
            res_target <= cur.target;
            res_err    <= bus_err;
        end
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
        arvalid && !arready |=> arvalid && $stable(araddr));

    a_r_outstanding: assert property (@(posedge clk) disable iff (!arst_n)
        rvalid |-> rready);

endmodule

`default_nettype wire

// ==== rvx_exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rvx_params.svh"

module rvx_exec_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic [`RVX_ILEN-1:0]   in_instr,
    input  logic [`RVX_XLEN-1:0]   in_rs1,
    input  logic [`RVX_XLEN-1:0]   in_rs2,
    input  logic [`RVX_XLEN-1:0]   in_pc,
    output logic                   res_valid,
    input  logic                   res_ready,
    output logic [`RVX_XLEN-1:0]   res_value,
    output logic [`RVX_REG_AW-1:0] res_rd,
    output logic                   res_wen,
    output logic                   res_taken,
    output logic [`RVX_XLEN-1:0]   res_target,
    output logic                   res_err,
    output logic [`RVX_AXI_AW-1:0] araddr,
    output logic [2:0]             arprot,
    output logic                   arvalid,
    input  logic                   arready,
    input  logic [`RVX_XLEN-1:0]   rdata,
    input  logic [1:0]             rresp,
    input  logic                   rvalid,
    output logic                   rready
);

    rvx_stage_if #(.payload_t(rvx_pkg::dec_op_t))  dec_if ();
    rvx_stage_if #(.payload_t(rvx_pkg::exe_res_t)) exe_if ();

    rvx_decode u_decode (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_instr (in_instr),
        .in_rs1   (in_rs1),
        .in_rs2   (in_rs2),
        .in_pc    (in_pc),
        .dec      (dec_if.source)
    );

    rvx_alu u_alu (
        .clk    (clk),
        .arst_n (arst_n),
        .dec    (dec_if.sink),
        .exe    (exe_if.source)
    );

    rvx_result u_result (
        .clk        (clk),
        .arst_n     (arst_n),
        .exe        (exe_if.sink),
        .araddr     (araddr),
        .arprot     (arprot),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res_value  (res_value),
        .res_rd     (res_rd),
        .res_wen    (res_wen),
        .res_taken  (res_taken),
        .res_target (res_target),
        .res_err    (res_err)
    );

endmodule

`default_nettype wire

// ==== tb_rvx_exec.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rvx_params.svh"

module tb_rvx_exec;

    logic                   clk = 1'b0;
    logic                   arst_n;
    logic                   in_valid;
    logic                   in_ready;
    logic [`RVX_ILEN-1:0]   in_instr;
    logic [`RVX_XLEN-1:0]   in_rs1;
    logic [`RVX_XLEN-1:0]   in_rs2;
    logic [`RVX_XLEN-1:0]   in_pc;
    logic                   res_valid;
    logic                   res_ready;
    logic [`RVX_XLEN-1:0]   res_value;
    logic [`RVX_REG_AW-1:0] res_rd;
    logic                   res_wen;
    logic                   res_taken;
    logic [`RVX_XLEN-1:0]   res_target;
    logic                   res_err;
    logic [`RVX_AXI_AW-1:0] araddr;
    logic [2:0]             arprot;
    logic                   arvalid;
    logic                   arready;
    logic [`RVX_XLEN-1:0]   rdata;
    logic [1:0]             rresp;
    logic                   rvalid;
    logic                   rready;

    // stimulus and expectation table
    logic [31:0] t_instr[$];
    logic [63:0] t_rs1[$];
    logic [63:0] t_rs2[$];
    logic [63:0] t_pc[$];
    logic [63:0] t_value[$];
    logic [4:0]  t_rd[$];
    logic        t_wen[$];
    logic        t_taken[$];
    logic [63:0] t_target[$];
    logic        t_err[$];
    logic        t_chk_val[$];

    int          acc_cyc[$];
    int          cyc = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    int          ar_count = 0;
    bit          hang = 1'b0;
    bit          bp_en = 1'b0;
    bit          entry_bad;
    logic [31:0] rng = 32'd51;
    int          axi_st = 0;
    logic [31:0] ar_addr;
    int          r_wait;

    rvx_exec_top u_dut (.*);

    initial begin
        forever begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, 5'd2, 5'd1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {imm, 5'd1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] btype(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    task automatic add_case(input logic [31:0] instr, input logic [63:0] rs1,
                            input logic [63:0] rs2, input logic [63:0] pc,
                            input logic [63:0] value, input logic [4:0] rd, input logic wen,
                            input logic taken, input logic [63:0] target,
                            input logic err, input logic chk_val);
        t_instr.push_back(instr);
        t_rs1.push_back(rs1);
        t_rs2.push_back(rs2);
        t_pc.push_back(pc);
        t_value.push_back(value);
        t_rd.push_back(rd);
        t_wen.push_back(wen);
        t_taken.push_back(taken);
        t_target.push_back(target);
        t_err.push_back(err);
        t_chk_val.push_back(chk_val);
    endtask

    task automatic build_table();
        logic [63:0] m1;
        m1 = '1;
        // alu, word forms, upper immediates
        add_case(rtype(7'h00, 3'd0, 5, 7'h33), 5, 7, 0, 12, 5, 1, 0, 0, 0, 1);
        add_case(rtype(7'h20, 3'd0, 5, 7'h33), 5, 7, 0, 64'hFFFF_FFFF_FFFF_FFFE, 5, 1, 0, 0, 0, 1);
        add_case(rtype(7'h00, 3'd7, 6, 7'h33), 'hF0F0, 'hFF00, 0, 'hF000, 6, 1, 0, 0, 0, 1);
        add_case(rtype(7'h00, 3'd6, 7, 7'h33), 'hF0F0, 'hFF00, 0, 'hFFF0, 7, 1, 0, 0, 0, 1);
        add_case(rtype(7'h00, 3'd4, 8, 7'h33), 'hF0F0, 'hFF00, 0, 'h0FF0, 8, 1, 0, 0, 0, 1);
        add_case(rtype(7'h00, 3'd1, 9, 7'h33), 1, 63, 0, 64'h8000_0000_0000_0000, 9, 1, 0, 0, 0, 1);
        add_case(rtype(7'h00, 3'd5, 9, 7'h33), 64'h8000_0000_0000_0000, 4, 0,
                 64'h0800_0000_0000_0000, 9, 1, 0, 0, 0, 1);
        add_case(rtype(7'h20, 3'd5, 9, 7'h33), 64'h8000_0000_0000_0000, 4, 0,
                 64'hF800_0000_0000_0000, 9, 1, 0, 0, 0, 1);
        add_case(rtype(7'h00, 3'd2, 10, 7'h33), m1, 1, 0, 1, 10, 1, 0, 0, 0, 1);
        add_case(rtype(7'h00, 3'd3, 10, 7'h33), m1, 1, 0, 0, 10, 1, 0, 0, 0, 1);
        add_case(itype(12'hFFD, 3'd0, 11, 7'h13), 10, 0, 0, 7, 11, 1, 0, 0, 0, 1);
        add_case(itype(12'h404, 3'd5, 11, 7'h13), 64'hFFFF_FFFF_FFFF_FF00, 0, 0,
                 64'hFFFF_FFFF_FFFF_FFF0, 11, 1, 0, 0, 0, 1);
        add_case({20'h12345, 5'd12, 7'h37}, 0, 0, 0, 'h1234_5000, 12, 1, 0, 0, 0, 1);
        add_case({20'h80000, 5'd12, 7'h37}, 0, 0, 0, 64'hFFFF_FFFF_8000_0000, 12, 1, 0, 0, 0, 1);
        add_case({20'h00001, 5'd13, 7'h17}, 0, 0, 'h1000_0000, 'h1000_1000, 13, 1, 0, 0, 0, 1);
        add_case(rtype(7'h00, 3'd0, 14, 7'h3B), 'h7FFF_FFFF, 1, 0,
                 64'hFFFF_FFFF_8000_0000, 14, 1, 0, 0, 0, 1);
        add_case(rtype(7'h20, 3'd0, 14, 7'h3B), 64'h1_0000_0000, 1, 0, m1, 14, 1, 0, 0, 0, 1);
        add_case(rtype(7'h00, 3'd1, 14, 7'h3B), 1, 'h3F, 0, 64'hFFFF_FFFF_8000_0000, 14, 1,
                 0, 0, 0, 1);
        // multiply and unsigned divide
        add_case(rtype(7'h01, 3'd0, 15, 7'h33), 64'h1_0000_0000, 64'h3_0000_0001, 0,
                 64'h0000_0001_0000_0000, 15, 1, 0, 0, 0, 1);
        add_case(rtype(7'h01, 3'd5, 15, 7'h33), 100, 7, 0, 14, 15, 1, 0, 0, 0, 1);
        add_case(rtype(7'h01, 3'd7, 15, 7'h33), 100, 7, 0, 2, 15, 1, 0, 0, 0, 1);
        add_case(rtype(7'h01, 3'd5, 15, 7'h33), 100, 0, 0, m1, 15, 1, 0, 0, 0, 1);
        add_case(rtype(7'h01, 3'd7, 15, 7'h33), 100, 0, 0, 100, 15, 1, 0, 0, 0, 1);
        // both outcomes of each branch condition
        add_case(btype(13'h010, 3'd0), 5, 5, 'h2000, 0, 0, 0, 1, 'h2010, 0, 0);
        add_case(btype(13'h010, 3'd0), 5, 6, 'h2000, 0, 0, 0, 0, 0, 0, 0);
        add_case(btype(13'h1FF8, 3'd1), 5, 6, 'h2000, 0, 0, 0, 1, 'h1FF8, 0, 0);
        add_case(btype(13'h1FF8, 3'd1), 5, 5, 'h2000, 0, 0, 0, 0, 0, 0, 0);
        add_case(btype(13'h010, 3'd4), m1, 1, 'h2000, 0, 0, 0, 1, 'h2010, 0, 0);
        add_case(btype(13'h010, 3'd4), 1, m1, 'h2000, 0, 0, 0, 0, 0, 0, 0);
        add_case(btype(13'h1FF8, 3'd5), 1, m1, 'h2000, 0, 0, 0, 1, 'h1FF8, 0, 0);
        add_case(btype(13'h1FF8, 3'd5), m1, 1, 'h2000, 0, 0, 0, 0, 0, 0, 0);
        add_case(btype(13'h010, 3'd6), 1, m1, 'h2000, 0, 0, 0, 1, 'h2010, 0, 0);
        add_case(btype(13'h010, 3'd6), m1, 1, 'h2000, 0, 0, 0, 0, 0, 0, 0);
        add_case(btype(13'h010, 3'd7), m1, 1, 'h2000, 0, 0, 0, 1, 'h2010, 0, 0);
        add_case(btype(13'h010, 3'd7), 1, m1, 'h2000, 0, 0, 0, 0, 0, 0, 0);
        // loads from the word at 0x1000 which reads 5A5AA5A5_0F0FE0F0
        add_case(itype(12'd0, 3'd0, 16, 7'h03), 'h1000, 0, 0, 64'hFFFF_FFFF_FFFF_FFF0, 16, 1,
                 0, 0, 0, 1);
        add_case(itype(12'd1, 3'd4, 16, 7'h03), 'h1000, 0, 0, 'hE0, 16, 1, 0, 0, 0, 1);
        add_case(itype(12'd2, 3'd0, 16, 7'h03), 'h1000, 0, 0, 'h0F, 16, 1, 0, 0, 0, 1);
        add_case(itype(12'd4, 3'd0, 16, 7'h03), 'h1000, 0, 0, 64'hFFFF_FFFF_FFFF_FFA5, 16, 1,
                 0, 0, 0, 1);
        add_case(itype(12'd7, 3'd4, 16, 7'h03), 'h1000, 0, 0, 'h5A, 16, 1, 0, 0, 0, 1);
        add_case(itype(12'd0, 3'd2, 17, 7'h03), 'h1000, 0, 0, 'h0F0F_E0F0, 17, 1, 0, 0, 0, 1);
        add_case(itype(12'd4, 3'd2, 17, 7'h03), 'h1000, 0, 0, 'h5A5A_A5A5, 17, 1, 0, 0, 0, 1);
        add_case(itype(12'd4, 3'd6, 17, 7'h03), 'h1000, 0, 0, 'h5A5A_A5A5, 17, 1, 0, 0, 0, 1);
        add_case(itype(12'd8, 3'd3, 18, 7'h03), 'h1000, 0, 0, 64'h5A5A_A5A5_0F0F_E0F8, 18, 1,
                 0, 0, 0, 1);
        add_case(itype(12'h10, 3'd3, 18, 7'h03), 'h1000, 0, 0, 64'h5A5A_A5A5_0F0F_E0E0, 18, 1,
                 0, 0, 0, 1);
        add_case(itype(12'd2, 3'd2, 19, 7'h03), 'h1000, 0, 0, 0, 19, 0, 0, 0, 1, 0);
        add_case(itype(12'd0, 3'd3, 19, 7'h03), 'h8000_0000, 0, 0, 0, 19, 0, 0, 0, 1, 1);
        // illegal encodings and rd 0
        add_case(32'h0000_007F, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0);
        add_case(rtype(7'h05, 3'd0, 20, 7'h33), 1, 2, 0, 0, 20, 0, 0, 0, 1, 0);
        add_case(rtype(7'h00, 3'd0, 0, 7'h33), 5, 7, 0, 12, 0, 0, 0, 0, 0, 1);
    endtask

    task automatic check_field(input int idx, input string what,
                               input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %0t entry %0d %s got %h expected %h", $time, idx, what, got, exp);
            entry_bad = 1'b1;
        end
    endtask

    // AXI4-Lite read slave and res_ready back-pressure
    initial begin
        forever begin
            @(posedge clk);
            #1;
            rng = xorshift(rng);
            res_ready = bp_en ? (rng[0] | rng[1]) : 1'b1;
            case (axi_st)
                0: if (arvalid) begin
                    ar_addr = araddr;
                    if (araddr[2:0] != 3'b000) begin
                        $display("ERR %0t araddr %h is not 8-byte aligned", $time, araddr);
                        n_fail++;
                    end
                    if (arprot !== 3'b000) begin
                        $display("ERR %0t arprot got %0d expected 0", $time, arprot);
                        n_fail++;
                    end
                    if (rng[8]) begin
                        arready = 1'b1;
                        axi_st  = 2;
                    end else begin
                        axi_st = 1;
                    end
                end
                1: begin
                    arready = 1'b1;
                    axi_st  = 2;
                end
                2: begin // AR transfer done at the last edge
                    arready  = 1'b0;
                    ar_count = ar_count + 1;
                    r_wait   = rng[10:9];
                    axi_st   = 3;
                end
                3: if (r_wait == 0) begin
                    if (rready !== 1'b1) begin
                        $display("rready was low while a read was outstanding");
                        n_fail++;
                    end
                    rvalid = 1'b1;
                    if (ar_addr >= 32'h8000_0000) begin
                        rresp = 2'b10;
                        rdata = '0;
                    end else begin
                        rresp = 2'b00;
                        rdata = {32'h0, ar_addr & 32'hFFFF_FFF8} ^ 64'h5A5A_A5A5_0F0F_F0F0;
                    end
                    axi_st = 4;
                end else begin
                    r_wait = r_wait - 1;
                end
                default: begin
                    rvalid = 1'b0;
                    axi_st = 0;
                end
            endcase
        end
    end

    task automatic drive_entries();
        int  t;
        bit  acc;
        for (int i = 0; i < t_instr.size(); i++) begin
            in_valid = 1'b1;
            in_instr = t_instr[i];
            in_rs1   = t_rs1[i];
            in_rs2   = t_rs2[i];
            in_pc    = t_pc[i];
            t        = 0;
            acc      = 1'b0;
            while (!acc && !hang && t < 300) begin
                @(negedge clk);
                if (in_ready) acc = 1'b1;
                else t++;
            end
            if (!acc) begin
                if (!hang) $display("timeout: entry %0d was never accepted", i);
                hang = 1'b1;
                break;
            end
            acc_cyc.push_back(cyc);
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    task automatic collect_results();
        int t;
        bit got;
        for (int i = 0; i < t_instr.size(); i++) begin
            t   = 0;
            got = 1'b0;
            while (!got && !hang && t < 300) begin
                @(negedge clk);
                if (res_valid && res_ready) got = 1'b1;
                else t++;
            end
            if (!got) begin
                if (!hang) $display("timeout: no result arrived for entry %0d", i);
                hang = 1'b1;
                break;
            end
            entry_bad = 1'b0;
            if (i == 0 && cyc - acc_cyc[0] != 3)
                check_field(i, "latency", cyc - acc_cyc[0], 3);
            if (t_chk_val[i]) check_field(i, "value", res_value, t_value[i]);
            if (t_wen[i]) check_field(i, "rd", res_rd, t_rd[i]);
            check_field(i, "wen", res_wen, t_wen[i]);
            check_field(i, "taken", res_taken, t_taken[i]);
            if (t_taken[i]) check_field(i, "target", res_target, t_target[i]);
            check_field(i, "err", res_err, t_err[i]);
            if (entry_bad) n_fail++;
            else n_pass++;
            $display("entry %0d instr %h %s", i, t_instr[i], entry_bad ? "failed" : "ok");
            bp_en = 1'b1; // back-pressure after the latency check
        end
    endtask

    initial begin
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_instr  = '0;
        in_rs1    = '0;
        in_rs2    = '0;
        in_pc     = '0;
        res_ready = 1'b1;
        arready   = 1'b0;
        rdata     = '0;
        rresp     = 2'b00;
        rvalid    = 1'b0;
        build_table();
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(posedge clk);
        #1;
        fork
            drive_entries();
            collect_results();
        join
        repeat (20) begin
            @(negedge clk);
            if (res_valid) begin
                $display("an extra result appeared after the last entry");
                n_fail++;
            end
        end
        // ten aligned loads and one bus error load reach AXI
        if (ar_count != 11) begin
            $display("ERR %0t AR count got %0d expected 11", $time, ar_count);
            n_fail++;
        end
        $display("passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0 && !hang) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
rvx_pkg.sv
rvx_stage_if.sv
rvx_decode.sv
rvx_alu.sv
rvx_result.sv
rvx_exec_top.sv
tb_rvx_exec.sv

// ==== Bender.yml ====
package:
  name: rvx_exec

export_include_dirs:
  - .

sources:
  - rvx_pkg.sv
  - rvx_stage_if.sv
  - rvx_decode.sv
  - rvx_alu.sv
  - rvx_result.sv
  - rvx_exec_top.sv
  - target: test
    files:
      - tb_rvx_exec.sv
